// ==== flist.f ====
+incdir+include
rtl/lsq_state_pkg.sv
rtl/lsq_bus_pkg.sv
rtl/lsq_ptr_if.sv
rtl/lsq_ptr_ctrl.sv
rtl/lsq_dep_check.sv
rtl/lsq_entry.sv
rtl/lsq_mem_arb.sv
rtl/lsq_cdb_sel.sv
rtl/lsq_top.sv
tb/lsq_tb.sv

// ==== tb/lsq_trace.txt ====
// Columns kind(1) cmd(1) size(1) rob(2) addr(4) data(8) as 17 hex digits per record
// Kinds 1 dispatch 2 address 3 retire 4 rollback 5 cdb 6 write 7 full 8 read 9 idle A end F stop
80000001000000000
50001000010040004
11201000000000000
20001001000000000
A0000000000000001
500040000BBBB0002
602000020AAAA0001
602000020BBBB0002
12202000000000000
12203000000000000
11204000000000000
200020020AAAA0001
200030020BBBB0002
20004002000000000
30002000000000000
30003000000000000
A0000000000000002
500060000CCCC0003
50007000010100010
80000004000000000
602000030CCCC0003
12205000000000000
11206000000000000
11207000000000000
20006003000000000
20007004000000000
90000000000000000
90000000000000000
200050030CCCC0003
30005000000000000
A0000000000000003
5000A0000EEEE0005
602000050DDDD0004
602000050EEEE0005
12208000000000000
12209000000000000
1120A000000000000
200080050DDDD0004
200090050EEEE0005
2000A005000000000
30008000000000000
30009000000000000
A0000000000000004
1120B000000000000
1120C000000000000
1120D000000000000
1120E000000000000
1120F000000000000
11210000000000000
11211000000000000
11212000000000000
90000000000000000
70000000000000001
11213000000000000
90000000000000000
70000000000000001
40000000000000000
90000000000000000
70000000000000000
80000002000000000
500140000BBBB0002
60200006012345678
11214000000000000
12215000000000000
20015006012345678
20014002000000000
30015000000000000
A0000000000000005
F0000000000000000

// ==== tb/lsq_tb.sv ====
// Trace-driven testbench for the load-store queue with a word memory model and random acknowledge
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_tb
    import lsq_state_pkg::*;
();

    logic                      clk_i;
    logic                      rst_i;
    logic                      rollback_i;
    logic                      dispatch_valid_i;
    mem_cmd_e                  dispatch_cmd_i;
    mem_size_e                 dispatch_size_i;
    logic [`LSQ_ROB_IDX_W-1:0] dispatch_rob_idx_i;
    logic                      fu_valid_i;
    logic [`LSQ_ROB_IDX_W-1:0] fu_rob_idx_i;
    logic [`LSQ_ADDR_W-1:0]    fu_addr_i;
    logic [`LSQ_DATA_W-1:0]    fu_data_i;
    logic                      mem_ack_i;
    logic [`LSQ_DATA_W-1:0]    mem_rdata_i;
    logic                      retire_valid_i;
    logic [`LSQ_ROB_IDX_W-1:0] retire_rob_idx_i;
    logic                      full_o;
    logic                      mem_req_valid_o;
    mem_cmd_e                  mem_cmd_o;
    mem_size_e                 mem_size_o;
    logic [`LSQ_ADDR_W-1:0]    mem_addr_o;
    logic [`LSQ_DATA_W-1:0]    mem_wdata_o;
    logic                      bc_valid_o;
    logic [`LSQ_ROB_IDX_W-1:0] bc_rob_idx_o;
    logic [`LSQ_DATA_W-1:0]    bc_data_o;

    // Memory model of 64 words indexed by the word address
    logic [`LSQ_DATA_W-1:0]    mem_model [0:63];
    // Trace records where unused slots read as stop records
    logic [67:0]               trace_mem [0:127];

    // Expected results in arrival order
    logic [`LSQ_ROB_IDX_W-1:0] exp_cdb_rob[$];
    logic [`LSQ_DATA_W-1:0]    exp_cdb_data[$];
    logic [`LSQ_ADDR_W-1:0]    exp_wr_addr[$];
    mem_size_e                 exp_wr_size[$];
    logic [`LSQ_DATA_W-1:0]    exp_wr_data[$];
    logic [`LSQ_ADDR_W-1:0]    exp_rd_addr[$];
    logic [`LSQ_ROB_IDX_W-1:0] retire_q[$];

    logic [31:0] lfsr;
    // Stores by ROB index whose address has not been sent yet
    logic [31:0] st_wait_mask;
    // Every dispatched store marked at its ROB index
    logic [31:0] st_rob_mask;
    // Store retires sent and memory writes seen
    int          st_retire_cnt;
    int          wr_cnt;
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    int          test_fail_cnt;
    int          cycle_cnt;
    int          cycle_limit;

    lsq_top dut0 (.*);

    assign mem_rdata_i = mem_model[mem_addr_o[7:2]];

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Watchdog ends a run that stops making progress
    initial begin
        wait (cycle_limit > 0 && cycle_cnt >= cycle_limit);
        $display("timeout: run stopped after %0d cycles", cycle_cnt);
        $display("Result: FAILED");
        $finish;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_cdb(input logic [`LSQ_ROB_IDX_W-1:0] rob,
                             input logic [`LSQ_DATA_W-1:0] data);
        logic [`LSQ_ROB_IDX_W-1:0] e_rob;
        logic [`LSQ_DATA_W-1:0]    e_data;
        if (exp_cdb_rob.size() == 0) begin
            $display("unexpected broadcast for ROB %0d at %0t", rob, $time);
            err_cnt++;
        end else begin
            e_rob  = exp_cdb_rob.pop_front();
            e_data = exp_cdb_data.pop_front();
            if (rob !== e_rob || data !== e_data) begin
                $display("ERR %0t: broadcast rob %0d data %h, expected rob %0d data %h",
                         $time, rob, data, e_rob, e_data);
                err_cnt++;
            end else begin
                check_cnt++;
            end
        end
    endtask

    task automatic check_write(input logic [`LSQ_ADDR_W-1:0] addr, input mem_size_e size,
                               input logic [`LSQ_DATA_W-1:0] data);
        logic [`LSQ_ADDR_W-1:0] e_addr;
        mem_size_e              e_size;
        logic [`LSQ_DATA_W-1:0] e_data;
        if (exp_wr_addr.size() == 0) begin
            $display("unexpected memory write to %h at %0t", addr, $time);
            err_cnt++;
        end else begin
            e_addr = exp_wr_addr.pop_front();
            e_size = exp_wr_size.pop_front();
            e_data = exp_wr_data.pop_front();
            if (addr !== e_addr || size !== e_size || data !== e_data) begin
                $display("ERR %0t: write %h %s %h, expected %h %s %h", $time,
                         addr, size.name(), data, e_addr, e_size.name(), e_data);
                err_cnt++;
            end else begin
                check_cnt++;
            end
        end
    endtask

    task automatic check_read(input logic [`LSQ_ADDR_W-1:0] addr);
        logic [`LSQ_ADDR_W-1:0] e_addr;
        if (exp_rd_addr.size() == 0) begin
            $display("memory read at %h with no load expecting it at %0t", addr, $time);
            err_cnt++;
        end else begin
            e_addr = exp_rd_addr.pop_front();
            if (addr !== e_addr) begin
                $display("ERR %0t: read address %h, expected %h", $time, addr, e_addr);
                err_cnt++;
            end else begin
                check_cnt++;
            end
        end
        if (st_wait_mask != 0) begin
            $display("load read issued while an older store address was unknown at %0t", $time);
            err_cnt++;
        end
    endtask

    task automatic check_full(input logic exp_full);
        if (full_o !== exp_full) begin
            $display("ERR %0t: full flag %b, expected %b", $time, full_o, exp_full);
            err_cnt++;
        end else begin
            check_cnt++;
        end
    endtask

    // ========================================
    // One clock step with output monitor
    // ========================================
    task automatic next_cycle();
        logic [`LSQ_ROB_IDX_W-1:0] ret_rob;
        @(posedge clk_i);
        // Outputs still hold this cycle's values here
        if (bc_valid_o) begin
            check_cdb(bc_rob_idx_o, bc_data_o);
            retire_q.push_back(bc_rob_idx_o);
        end
        if (mem_req_valid_o && mem_ack_i) begin
            if (mem_cmd_o == STORE) begin
                // A store writes only after its own retire
                if (wr_cnt >= st_retire_cnt) begin
                    $display("memory write to %h came before its store was retired at %0t",
                             mem_addr_o, $time);
                    err_cnt++;
                end
                wr_cnt++;
                check_write(mem_addr_o, mem_size_o, mem_wdata_o);
                mem_model[mem_addr_o[7:2]] <= mem_wdata_o;
            end else begin
                check_read(mem_addr_o);
            end
        end
        // Default drive that records override after this
        dispatch_valid_i <= 1'b0;
        fu_valid_i       <= 1'b0;
        rollback_i       <= 1'b0;
        retire_valid_i   <= 1'b0;
        lfsr = lfsr_step(lfsr);
        mem_ack_i <= lfsr[0];
        if (retire_q.size() > 0) begin
            ret_rob = retire_q.pop_front();
            retire_valid_i   <= 1'b1;
            retire_rob_idx_i <= ret_rob;
            if (st_rob_mask[ret_rob]) begin
                st_retire_cnt++;
            end
        end
    endtask

    function automatic bit drained();
        return exp_cdb_rob.size() == 0 && exp_wr_addr.size() == 0 &&
               exp_rd_addr.size() == 0 && retire_q.size() == 0;
    endfunction

    // ========================================
    // Trace player
    // ========================================
    initial begin
        logic [67:0]               rec;
        logic [3:0]                kind;
        logic [`LSQ_ROB_IDX_W-1:0] rob;
        logic [`LSQ_ADDR_W-1:0]    addr;
        logic [`LSQ_DATA_W-1:0]    data;
        int                        idx;
        int                        nrec;
        int                        err_at_start;

        rst_i              = 1'b1;
        rollback_i         = 1'b0;
        dispatch_valid_i   = 1'b0;
        dispatch_cmd_i     = NONE;
        dispatch_size_i    = BYTE;
        dispatch_rob_idx_i = '0;
        fu_valid_i         = 1'b0;
        fu_rob_idx_i       = '0;
        fu_addr_i          = '0;
        fu_data_i          = '0;
        mem_ack_i          = 1'b0;
        retire_valid_i     = 1'b0;
        retire_rob_idx_i   = '0;
        lfsr               = 32'h2723e152;
        st_wait_mask       = '0;
        st_rob_mask        = '0;
        st_retire_cnt      = 0;
        wr_cnt             = 0;
        err_cnt            = 0;
        check_cnt          = 0;
        test_cnt           = 0;
        test_fail_cnt      = 0;
        cycle_cnt          = 0;
        cycle_limit        = 0;
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = 32'h1000_0000 + i * 32'h0001_0001;
        end
        for (int i = 0; i < 128; i++) begin
            trace_mem[i] = '1;
        end
        $readmemh("tb/lsq_trace.txt", trace_mem);
        nrec = 0;
        while (nrec < 128 && trace_mem[nrec][67:64] != 4'hF) begin
            nrec++;
        end
        cycle_limit = 40 * (nrec + 1);

        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;

        idx          = 0;
        err_at_start = 0;
        while (trace_mem[idx][67:64] != 4'hF) begin
            rec  = trace_mem[idx];
            idx++;
            kind = rec[67:64];
            rob  = rec[52:48];
            addr = rec[47:32];
            data = rec[31:0];
            case (kind)
                4'h1: begin
                    next_cycle();
                    dispatch_valid_i   <= 1'b1;
                    dispatch_cmd_i     <= mem_cmd_e'(rec[61:60]);
                    dispatch_size_i    <= mem_size_e'(rec[57:56]);
                    dispatch_rob_idx_i <= rob;
                    if (mem_cmd_e'(rec[61:60]) == STORE) begin
                        st_wait_mask[rob] = 1'b1;
                        st_rob_mask[rob]  = 1'b1;
                    end
                end
                4'h2: begin
                    next_cycle();
                    fu_valid_i   <= 1'b1;
                    fu_rob_idx_i <= rob;
                    fu_addr_i    <= addr;
                    fu_data_i    <= data;
                    st_wait_mask[rob] = 1'b0;
                end
                4'h3: retire_q.push_back(rob);
                4'h4: begin
                    next_cycle();
                    rollback_i <= 1'b1;
                    st_wait_mask = '0;
                end
                4'h5: begin
                    exp_cdb_rob.push_back(rob);
                    exp_cdb_data.push_back(data);
                end
                4'h6: begin
                    exp_wr_addr.push_back(addr);
                    exp_wr_size.push_back(mem_size_e'(rec[57:56]));
                    exp_wr_data.push_back(data);
                end
                4'h7: begin
                    next_cycle();
                    check_full(data[0]);
                end
                4'h8: exp_rd_addr.push_back(addr);
                4'h9: next_cycle();
                4'hA: begin
                    while (!drained()) begin
                        next_cycle();
                    end
                    // Let the last entries leave from the head
                    repeat (3) next_cycle();
                    test_cnt++;
                    if (err_cnt == err_at_start) begin
                        $display("test %0d: passed", data);
                    end else begin
                        test_fail_cnt++;
                        $display("test %0d: failed with %0d errors", data, err_cnt - err_at_start);
                    end
                    err_at_start = err_cnt;
                end
                default: begin
                    $display("trace record %0d has unknown kind %h", idx - 1, kind);
                    err_cnt++;
                end
            endcase
        end

        $display("tests: %0d run, %0d failed; checks: %0d passed, %0d errors",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/lsq_top.sv ====
// Load-store queue top level with pointer control, eight entries and two selectors
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_top
    import lsq_state_pkg::*;
    import lsq_bus_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      rollback_i,
    // Dispatch, one per cycle in program order
    input  logic                      dispatch_valid_i,
    input  mem_cmd_e                  dispatch_cmd_i,
    input  mem_size_e                 dispatch_size_i,
    input  logic [`LSQ_ROB_IDX_W-1:0] dispatch_rob_idx_i,
    // Address unit result
    input  logic                      fu_valid_i,
    input  logic [`LSQ_ROB_IDX_W-1:0] fu_rob_idx_i,
    input  logic [`LSQ_ADDR_W-1:0]    fu_addr_i,
    input  logic [`LSQ_DATA_W-1:0]    fu_data_i,
    // Memory response
    input  logic                      mem_ack_i,
    input  logic [`LSQ_DATA_W-1:0]    mem_rdata_i,
    // ROB retire channel
    input  logic                      retire_valid_i,
    input  logic [`LSQ_ROB_IDX_W-1:0] retire_rob_idx_i,
    output logic                      full_o,
    // Memory request
    output logic                      mem_req_valid_o,
    output mem_cmd_e                  mem_cmd_o,
    output mem_size_e                 mem_size_o,
    output logic [`LSQ_ADDR_W-1:0]    mem_addr_o,
    output logic [`LSQ_DATA_W-1:0]    mem_wdata_o,
    // Load result broadcast
    output logic                      bc_valid_o,
    output logic [`LSQ_ROB_IDX_W-1:0] bc_rob_idx_o,
    output logic [`LSQ_DATA_W-1:0]    bc_data_o
);

    lsq_ptr_if                         ptr ();
    lsq_entry_t [`LSQ_ENTRY_NUM-1:0]   entries;
    logic       [`LSQ_ENTRY_NUM-1:0]   mem_done;
    logic       [`LSQ_ENTRY_NUM-1:0]   bc_done;
    mem_req_t                          mem_req;
    cdb_pkt_t                          bc_pkt;

    assign ptr.rollback = rollback_i;

    lsq_ptr_ctrl u_ptr_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .dispatch_valid_i (dispatch_valid_i),
        .entries_i        (entries),
        .ptr              (ptr.ctrl),
        .full_o           (full_o)
    );

    // ========================================
    // Entry array
    // ========================================
    for (genvar i = 0; i < `LSQ_ENTRY_NUM; i++) begin : g_entry
        lsq_entry #(.ENTRY_IDX(i)) u_entry (
            .clk_i              (clk_i),
            .rst_i              (rst_i),
            .ptr                (ptr.entry),
            .dispatch_cmd_i     (dispatch_cmd_i),
            .dispatch_size_i    (dispatch_size_i),
            .dispatch_rob_idx_i (dispatch_rob_idx_i),
            .fu_valid_i         (fu_valid_i),
            .fu_rob_idx_i       (fu_rob_idx_i),
            .fu_addr_i          (fu_addr_i),
            .fu_data_i          (fu_data_i),
            .retire_valid_i     (retire_valid_i),
            .retire_rob_idx_i   (retire_rob_idx_i),
            .mem_done_i         (mem_done[i]),
            .mem_rdata_i        (mem_rdata_i),
            .bc_done_i          (bc_done[i]),
            .entries_i          (entries),
            .entry_o            (entries[i])
        );
    end

    // ========================================
    // Shared memory port and broadcast port
    // ========================================
    lsq_mem_arb u_mem_arb (
        .head_i     (ptr.head),
        .entries_i  (entries),
        .mem_ack_i  (mem_ack_i),
        .mem_req_o  (mem_req),
        .mem_done_o (mem_done)
    );

    lsq_cdb_sel u_cdb_sel (
        .head_i    (ptr.head),
        .entries_i (entries),
        .bc_o      (bc_pkt),
        .bc_done_o (bc_done)
    );

    // Split packets onto the plain ports
    assign mem_req_valid_o = mem_req.valid;
    assign mem_cmd_o       = mem_req.cmd;
    assign mem_size_o      = mem_req.size;
    assign mem_addr_o      = mem_req.addr;
    assign mem_wdata_o     = mem_req.data;
    assign bc_valid_o      = bc_pkt.valid;
    assign bc_rob_idx_o    = bc_pkt.rob_idx;
    assign bc_data_o       = bc_pkt.data;

endmodule

// ==== rtl/lsq_cdb_sel.sv ====
// Oldest-first selection of the completed load that drives the broadcast port
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_cdb_sel
    import lsq_state_pkg::*;
    import lsq_bus_pkg::*;
(
    input  logic [`LSQ_IDX_W-1:0]           head_i,
    input  lsq_entry_t [`LSQ_ENTRY_NUM-1:0] entries_i,
    output cdb_pkt_t                        bc_o,
    output logic [`LSQ_ENTRY_NUM-1:0]       bc_done_o
);

    logic [`LSQ_IDX_W-1:0] scan_idx;
    logic                  found;

    // Younger completed loads stay in LOAD_CP until their turn
    always_comb begin
        bc_o      = '0;
        bc_done_o = '0;
        found     = 1'b0;
        scan_idx  = head_i;
        for (int k = 0; k < `LSQ_ENTRY_NUM; k++) begin
            scan_idx = head_i + `LSQ_IDX_W'(k);
            if (!found && entries_i[scan_idx].state == LOAD_CP) begin
                found               = 1'b1;
                bc_o.valid          = 1'b1;
                bc_o.rob_idx        = entries_i[scan_idx].rob_idx;
                bc_o.data           = entries_i[scan_idx].data;
                bc_done_o[scan_idx] = 1'b1;
            end
        end
    end

endmodule

// ==== rtl/lsq_mem_arb.sv ====
// Oldest-first memory port arbiter with acknowledge routing back to the winner
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_mem_arb
    import lsq_state_pkg::*;
    import lsq_bus_pkg::*;
(
    input  logic [`LSQ_IDX_W-1:0]           head_i,
    input  lsq_entry_t [`LSQ_ENTRY_NUM-1:0] entries_i,
    input  logic                            mem_ack_i,
    output mem_req_t                        mem_req_o,
    output logic [`LSQ_ENTRY_NUM-1:0]       mem_done_o
);

    logic [`LSQ_IDX_W-1:0] scan_idx;
    logic [`LSQ_IDX_W-1:0] sel;
    logic                  found;

    always_comb begin
        mem_req_o  = '0;
        mem_done_o = '0;
        found      = 1'b0;
        sel        = head_i;
        scan_idx   = head_i;
        // First requester in age order wins
        for (int k = 0; k < `LSQ_ENTRY_NUM; k++) begin
            scan_idx = head_i + `LSQ_IDX_W'(k);
            if (!found && (entries_i[scan_idx].state == RD_MEM ||
                           entries_i[scan_idx].state == WR_MEM)) begin
                found = 1'b1;
                sel   = scan_idx;
            end
        end
        if (found) begin
            mem_req_o.valid = 1'b1;
            mem_req_o.cmd   = entries_i[sel].cmd;
            mem_req_o.size  = entries_i[sel].size;
            mem_req_o.addr  = entries_i[sel].addr;
            // Reads carry no write data
            mem_req_o.data  = (entries_i[sel].state == WR_MEM) ? entries_i[sel].data : '0;
            mem_done_o[sel] = mem_ack_i;
        end
    end

endmodule

// ==== rtl/lsq_entry.sv ====
// Per-entry controller running one load or store from dispatch to free
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_entry
    import lsq_state_pkg::*;
#(
    parameter int ENTRY_IDX = 0
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    lsq_ptr_if.entry                        ptr,
    input  mem_cmd_e                        dispatch_cmd_i,
    input  mem_size_e                       dispatch_size_i,
    input  logic [`LSQ_ROB_IDX_W-1:0]       dispatch_rob_idx_i,
    input  logic                            fu_valid_i,
    input  logic [`LSQ_ROB_IDX_W-1:0]       fu_rob_idx_i,
    input  logic [`LSQ_ADDR_W-1:0]          fu_addr_i,
    input  logic [`LSQ_DATA_W-1:0]          fu_data_i,
    input  logic                            retire_valid_i,
    input  logic [`LSQ_ROB_IDX_W-1:0]       retire_rob_idx_i,
    // Granted request acknowledged this cycle
    input  logic                            mem_done_i,
    input  logic [`LSQ_DATA_W-1:0]          mem_rdata_i,
    input  logic                            bc_done_i,
    input  lsq_entry_t [`LSQ_ENTRY_NUM-1:0] entries_i,
    output lsq_entry_t                      entry_o
);

    lsq_entry_t             entry_d;
    lsq_entry_t             probe;
    logic                   fu_hit;
    logic                   ret_hit;
    logic                   older_known;
    logic                   dep_hit;
    logic [`LSQ_DATA_W-1:0] dep_data;

    assign fu_hit  = fu_valid_i && (fu_rob_idx_i == entry_o.rob_idx);
    assign ret_hit = retire_valid_i && (retire_rob_idx_i == entry_o.rob_idx);

    // Arriving load address is compared in the same cycle it is captured
    always_comb begin
        probe = entry_o;
        if (entry_o.state == ADDR) begin
            probe.addr = fu_addr_i;
        end
    end

    lsq_dep_check #(.ENTRY_IDX(ENTRY_IDX)) u_dep_check (
        .head_i        (ptr.head),
        .entries_i     (entries_i),
        .self_i        (probe),
        .older_known_o (older_known),
        .dep_hit_o     (dep_hit),
        .dep_data_o    (dep_data)
    );

    // ========================================
    // Next-state logic
    // ========================================
    always_comb begin
        entry_d = entry_o;
        if (ptr.alloc[ENTRY_IDX]) begin
            // New op at tail, address still unknown
            entry_d.state      = ADDR;
            entry_d.cmd        = dispatch_cmd_i;
            entry_d.size       = dispatch_size_i;
            entry_d.rob_idx    = dispatch_rob_idx_i;
            entry_d.addr_valid = 1'b0;
            entry_d.data_valid = 1'b0;
        end else if (ptr.free[ENTRY_IDX]) begin
            entry_d.state      = IDLE;
            entry_d.cmd        = NONE;
            entry_d.addr_valid = 1'b0;
            entry_d.data_valid = 1'b0;
        end else begin
            case (entry_o.state)
                ADDR: begin
                    if (fu_hit) begin
                        entry_d.addr       = fu_addr_i;
                        entry_d.addr_valid = 1'b1;
                        if (entry_o.cmd == STORE) begin
                            // Store data comes with its address
                            entry_d.data       = fu_data_i;
                            entry_d.data_valid = 1'b1;
                            entry_d.state      = ROB_RETIRE;
                        end else if (older_known && !dep_hit) begin
                            entry_d.state = RD_MEM;
                        end else begin
                            entry_d.state = DEPEND;
                        end
                    end
                end
                // Load waits for every older store address
                DEPEND: begin
                    if (older_known) begin
                        if (dep_hit) begin
                            // Forward from nearest matching store
                            entry_d.data       = dep_data;
                            entry_d.data_valid = 1'b1;
                            entry_d.state      = LOAD_CP;
                        end else begin
                            entry_d.state = RD_MEM;
                        end
                    end
                end
                RD_MEM: begin
                    if (mem_done_i) begin
                        entry_d.data       = mem_rdata_i;
                        entry_d.data_valid = 1'b1;
                        entry_d.state      = LOAD_CP;
                    end
                end
                LOAD_CP: begin
                    if (bc_done_i) begin
                        entry_d.state = ROB_RETIRE;
                    end
                end
                ROB_RETIRE: begin
                    if (ret_hit) begin
                        entry_d.state = (entry_o.cmd == STORE) ? WR_MEM : RETIRE;
                    end
                end
                WR_MEM: begin
                    if (mem_done_i) begin
                        entry_d.state = RETIRE;
                    end
                end
                default: begin
                    // IDLE and RETIRE wait for a pointer strobe
                    entry_d = entry_o;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || ptr.rollback) begin
            entry_o.state      <= IDLE;
            entry_o.cmd        <= NONE;
            entry_o.addr_valid <= 1'b0;
            entry_o.data_valid <= 1'b0;
        end else begin
            entry_o <= entry_d;
        end
    end

endmodule

// ==== rtl/lsq_dep_check.sv ====
// Older-store scan giving address-known status and the nearest matching store data
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_dep_check
    import lsq_state_pkg::*;
#(
    parameter int ENTRY_IDX = 0
) (
    input  logic [`LSQ_IDX_W-1:0]           head_i,
    input  lsq_entry_t [`LSQ_ENTRY_NUM-1:0] entries_i,
    input  lsq_entry_t                      self_i,
    output logic                            older_known_o,
    output logic                            dep_hit_o,
    output logic [`LSQ_DATA_W-1:0]          dep_data_o
);

    logic [`LSQ_IDX_W-1:0] scan_idx;
    logic                  reached;

    // ========================================
    // Age-ordered walk from head to self
    // ========================================
    always_comb begin
        older_known_o = 1'b1;
        dep_hit_o     = 1'b0;
        dep_data_o    = '0;
        reached       = 1'b0;
        scan_idx      = head_i;
        for (int k = 0; k < `LSQ_ENTRY_NUM; k++) begin
            // Index wraps past entry 7 by width
            scan_idx = head_i + `LSQ_IDX_W'(k);
            // Everything from here on is self or younger
            if (scan_idx == `LSQ_IDX_W'(ENTRY_IDX)) begin
                reached = 1'b1;
            end
            if (!reached && entries_i[scan_idx].cmd == STORE) begin
                if (!entries_i[scan_idx].addr_valid) begin
                    older_known_o = 1'b0;
                end else if (entries_i[scan_idx].addr == self_i.addr &&
                             entries_i[scan_idx].size == self_i.size) begin
                    // Later hits are nearer and overwrite earlier ones
                    dep_hit_o  = 1'b1;
                    dep_data_o = entries_i[scan_idx].data;
                end
            end
        end
    end

endmodule

// ==== rtl/lsq_ptr_ctrl.sv ====
// Head and tail pointer control with occupancy count and allocate/free strobes
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_ptr_ctrl
    import lsq_state_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            dispatch_valid_i,
    input  lsq_entry_t [`LSQ_ENTRY_NUM-1:0] entries_i,
    lsq_ptr_if.ctrl                         ptr,
    output logic                            full_o
);

    // One extra bit so a full queue is distinct from an empty one
    logic [`LSQ_IDX_W:0] count_q;
    logic                do_alloc;
    logic                do_free;

    assign full_o   = (count_q == `LSQ_ENTRY_NUM);
    // Dispatch ignored while full
    assign do_alloc = dispatch_valid_i && !full_o;
    // Only the head may leave, in order
    assign do_free  = (entries_i[ptr.head].state == RETIRE);

    // One-hot strobes at tail and head
    always_comb begin
        ptr.alloc           = '0;
        ptr.free            = '0;
        ptr.alloc[ptr.tail] = do_alloc;
        ptr.free[ptr.head]  = do_free;
    end

    // ========================================
    // Pointer and count registers
    // ========================================
    always_ff @(posedge clk_i) begin
        if (rst_i || ptr.rollback) begin
            ptr.head <= '0;
            ptr.tail <= '0;
            count_q  <= '0;
        end else begin
            ptr.head <= ptr.head + `LSQ_IDX_W'(do_free);
            ptr.tail <= ptr.tail + `LSQ_IDX_W'(do_alloc);
            // Alloc and free in one cycle leave the count as is
            count_q  <= count_q + (`LSQ_IDX_W+1)'(do_alloc) - (`LSQ_IDX_W+1)'(do_free);
        end
    end

endmodule

// ==== rtl/lsq_ptr_if.sv ====
// Queue pointer bundle between pointer control and the entry controllers
`timescale 1ns/1ps
`include "lsq_macros.svh"

interface lsq_ptr_if;

    // Oldest entry and next entry to allocate
    logic [`LSQ_IDX_W-1:0]     head;
    logic [`LSQ_IDX_W-1:0]     tail;
    // One-cycle strobes, one bit per entry
    logic [`LSQ_ENTRY_NUM-1:0] alloc;
    logic [`LSQ_ENTRY_NUM-1:0] free;
    // Flush of the whole queue
    logic                      rollback;

    // Pointer control owns the pointers and strobes
    modport ctrl (
        output head, tail, alloc, free,
        input  rollback
    );

    // Entries only observe
    modport entry (
        input head, tail, alloc, free, rollback
    );

endinterface

// ==== rtl/lsq_bus_pkg.sv ====
// Load-store queue bus packets for the memory request and the result broadcast
`include "lsq_macros.svh"

package lsq_bus_pkg;

    import lsq_state_pkg::*;

    // Memory request from the selected entry, 53 bits
    typedef struct packed {
        logic                   valid;
        mem_cmd_e               cmd;
        mem_size_e              size;
        logic [`LSQ_ADDR_W-1:0] addr;
        // Only meaningful for stores
        logic [`LSQ_DATA_W-1:0] data;
    } mem_req_t;

    // Load result on the broadcast port, 38 bits
    typedef struct packed {
        logic                      valid;
        logic [`LSQ_ROB_IDX_W-1:0] rob_idx;
        logic [`LSQ_DATA_W-1:0]    data;
    } cdb_pkt_t;

endpackage

// ==== rtl/lsq_state_pkg.sv ====
// Load-store queue entry types: state, memory command, access size and entry record
`include "lsq_macros.svh"

package lsq_state_pkg;

    // ========================================
    // Per-entry FSM states
    // ========================================
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        ADDR       = 3'd1,
        DEPEND     = 3'd2,
        RD_MEM     = 3'd3,
        LOAD_CP    = 3'd4,
        ROB_RETIRE = 3'd5,
        WR_MEM     = 3'd6,
        RETIRE     = 3'd7
    } lsq_state_e;

    // Memory command, NONE marks an empty entry
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } mem_cmd_e;

    // Access size
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    // ========================================
    // One queue entry, 62 bits
    // ========================================
    typedef struct packed {
        lsq_state_e               state;
        mem_cmd_e                 cmd;
        logic [`LSQ_ROB_IDX_W-1:0] rob_idx;
        mem_size_e                size;
        logic [`LSQ_ADDR_W-1:0]    addr;
        logic                     addr_valid;
        logic [`LSQ_DATA_W-1:0]    data;
        logic                     data_valid;
    } lsq_entry_t;

endpackage

// ==== include/lsq_macros.svh ====
// Load-store queue sizing constants for entries, address, data and ROB index
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// Queue depth and the pointer width that indexes it
`define LSQ_ENTRY_NUM   8
`define LSQ_IDX_W       3

// Memory address and data widths
`define LSQ_ADDR_W      16
`define LSQ_DATA_W      32

// ROB index carried by every entry
`define LSQ_ROB_IDX_W   5

`endif
